// File: common/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data and instruction word width
`define XLEN 32

// Architectural registers, 5-bit index fixed by the format
`define REG_COUNT 32

// Memory depths in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// Word address width of the program counter
`define IMEM_AW ($clog2(`IMEM_DEPTH))

`endif

// File: common/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// --------------------
	// Encodings
	// --------------------

	// Major opcodes of the supported subset
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opBeq = 6'h04,
		opAddi = 6'h08,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	// R-type function field
	typedef enum logic [5:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// Operation handed from decode to the ALU
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	// --------------------
	// Instruction formats
	// --------------------

	typedef struct packed {
		opcodeT opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functT funct;
	} rFormatT;

	typedef struct packed {
		opcodeT opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFormatT;

	// Same fetched word, read as R or I format by opcode
	typedef union packed {
		rFormatT r;
		iFormatT i;
	} instrT;

endpackage

`default_nettype wire

// File: fetch/fetchStage.sv
`default_nettype none

`include "mips_params.svh"

module fetchStage
(
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic imemWe,
	input wire logic [`IMEM_AW-1:0] imemAddr,
	input wire logic [`XLEN-1:0] imemData,
	input wire logic branchTaken,
	input wire logic [`IMEM_AW-1:0] branchTarget,
	output mipsPkg::instrT instrD,
	output logic [`IMEM_AW-1:0] pcPlusOneD,
	output logic validD
);

	// --------------------
	// PC and instruction memory
	// --------------------

	// Word-addressed PC, no shift by two
	logic [`IMEM_AW-1:0] pc;
	logic [`IMEM_AW-1:0] pcPlusOne;
	logic [`XLEN-1:0] imem [`IMEM_DEPTH];

	assign pcPlusOne = pc + 1'b1;

	// Held at zero while the program is loaded
	always_ff @(posedge clk)
	begin
		if (rst || !run)
			pc <= '0;
		else if (branchTaken)
			pc <= branchTarget;
		else
			pc <= pcPlusOne;
	end

	// Load port, only while stopped
	always_ff @(posedge clk)
	begin
		if (imemWe && !run)
			imem[imemAddr] <= imemData;
	end

	// --------------------
	// IF/ID register
	// --------------------

	// Taken branch in decode kills the slot fetched behind it
	always_ff @(posedge clk)
	begin
		if (rst || !run)
			validD <= 1'b0;
		else
			validD <= !branchTaken;
	end

	// Payload, qualified by validD
	always_ff @(posedge clk)
	begin
		instrD <= imem[pc];
		pcPlusOneD <= pcPlusOne;
	end

endmodule

`default_nettype wire

// File: decode/decodeStage.sv
`default_nettype none

`include "mips_params.svh"

module decodeStage
(
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire mipsPkg::instrT instrD,
	input wire logic [`IMEM_AW-1:0] pcPlusOneD,
	input wire logic validD,
	input wire logic wbValid,
	input wire logic [4:0] wbReg,
	input wire logic [`XLEN-1:0] wbData,
	output logic branchTaken,
	output logic [`IMEM_AW-1:0] branchTarget,
	output logic validE,
	output logic regWriteE,
	output logic memToRegE,
	output logic memWriteE,
	output logic aluSrcE,
	output logic regDstE,
	output mipsPkg::aluOpT aluOpE,
	output logic [`XLEN-1:0] rd1E,
	output logic [`XLEN-1:0] rd2E,
	output logic [`XLEN-1:0] signImmE,
	output logic [4:0] rtE,
	output logic [4:0] rdE
);

	// Decoded control levels
	logic known;
	logic regWrite;
	logic memToReg;
	logic memWrite;
	logic aluSrc;
	logic regDst;
	logic isBranch;
	mipsPkg::aluOpT aluOp;

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic [`XLEN-1:0] rd1;
	logic [`XLEN-1:0] rd2;
	logic [`XLEN-1:0] signImm;
	logic [4:0] rsD;
	logic [4:0] rtD;

	// --------------------
	// Control decode
	// --------------------

	// Unknown opcode or funct leaves known low
	always_comb
	begin
		known = 1'b0;
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrc = 1'b0;
		regDst = 1'b0;
		isBranch = 1'b0;
		aluOp = mipsPkg::aluAdd;
		case (instrD.r.opcode)
			mipsPkg::opRtype:
			begin
				regWrite = 1'b1;
				regDst = 1'b1;
				known = 1'b1;
				// Funct picks the ALU operation
				case (instrD.r.funct)
					mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: aluOp = mipsPkg::aluOr;
					mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
					default: known = 1'b0;
				endcase
			end
			mipsPkg::opAddi:
			begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				known = 1'b1;
			end
			mipsPkg::opLw:
			begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				aluSrc = 1'b1;
				known = 1'b1;
			end
			mipsPkg::opSw:
			begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
				known = 1'b1;
			end
			mipsPkg::opBeq:
			begin
				isBranch = 1'b1;
				known = 1'b1;
			end
			default: known = 1'b0;
		endcase
	end

	// --------------------
	// Register file
	// --------------------

	assign rsD = instrD.r.rs;
	assign rtD = instrD.r.rt;

	// wbValid is never high for register zero
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int k = 0; k < `REG_COUNT; k++)
				regs[k] <= '0;
		end
		else if (wbValid)
		begin
			regs[wbReg] <= wbData;
		end
	end

	// Same-cycle write returns the new value
	assign rd1 = (rsD == 5'd0) ? '0 : (wbValid && wbReg == rsD) ? wbData : regs[rsD];
	assign rd2 = (rtD == 5'd0) ? '0 : (wbValid && wbReg == rtD) ? wbData : regs[rtD];

	assign signImm = {{16{instrD.i.imm[15]}}, instrD.i.imm};

	// --------------------
	// Branch resolve
	// --------------------

	// Word target relative to the slot after beq
	assign branchTaken = validD && isBranch && (rd1 == rd2);
	assign branchTarget = pcPlusOneD + signImm[`IMEM_AW-1:0];

	// --------------------
	// ID/EX register
	// --------------------

	// Bubble on unknown encodings or squashed slot
	always_ff @(posedge clk)
	begin
		if (rst || !run)
		begin
			validE <= 1'b0;
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
		end
		else
		begin
			validE <= validD && known;
			regWriteE <= validD && known && regWrite;
			memToRegE <= validD && known && memToReg;
			memWriteE <= validD && known && memWrite;
		end
	end

	// Datapath and mux selects
	always_ff @(posedge clk)
	begin
		aluSrcE <= aluSrc;
		regDstE <= regDst;
		aluOpE <= aluOp;
		rd1E <= rd1;
		rd2E <= rd2;
		signImmE <= signImm;
		rtE <= rtD;
		rdE <= instrD.r.rd;
	end

endmodule

`default_nettype wire

// File: logic/aluExec.sv
`default_nettype none

`include "mips_params.svh"

module aluExec
(
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic validE,
	input wire logic regWriteE,
	input wire logic memToRegE,
	input wire logic memWriteE,
	input wire logic aluSrcE,
	input wire logic regDstE,
	input wire mipsPkg::aluOpT aluOpE,
	input wire logic [`XLEN-1:0] rd1E,
	input wire logic [`XLEN-1:0] rd2E,
	input wire logic [`XLEN-1:0] signImmE,
	input wire logic [4:0] rtE,
	input wire logic [4:0] rdE,
	output logic validM,
	output logic regWriteM,
	output logic memToRegM,
	output logic memWriteM,
	output logic [`XLEN-1:0] aluOutM,
	output logic [`XLEN-1:0] writeDataM,
	output logic [4:0] writeRegM
);

	logic [`XLEN-1:0] srcB;
	logic [`XLEN-1:0] aluOut;
	logic [4:0] writeReg;

	// Immediate for addi, lw, sw
	assign srcB = aluSrcE ? signImmE : rd2E;
	// rd for R-type, rt otherwise
	assign writeReg = regDstE ? rdE : rtE;

	// --------------------
	// ALU
	// --------------------

	always_comb
	begin
		case (aluOpE)
			mipsPkg::aluAdd: aluOut = rd1E + srcB;
			mipsPkg::aluSub: aluOut = rd1E - srcB;
			mipsPkg::aluAnd: aluOut = rd1E & srcB;
			mipsPkg::aluOr: aluOut = rd1E | srcB;
			// Signed compare
			mipsPkg::aluSlt: aluOut = {{(`XLEN-1){1'b0}}, $signed(rd1E) < $signed(srcB)};
			default: aluOut = '0;
		endcase
	end

	// --------------------
	// EX/MEM register
	// --------------------

	always_ff @(posedge clk)
	begin
		if (rst || !run)
		begin
			validM <= 1'b0;
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
		end
		else
		begin
			validM <= validE;
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
		end
	end

	// Store data is the unmodified rt value
	always_ff @(posedge clk)
	begin
		aluOutM <= aluOut;
		writeDataM <= rd2E;
		writeRegM <= writeReg;
	end

endmodule

`default_nettype wire

// File: logic/dataMemory.sv
`default_nettype none

`include "mips_params.svh"

module dataMemory
(
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic validM,
	input wire logic regWriteM,
	input wire logic memToRegM,
	input wire logic memWriteM,
	input wire logic [`XLEN-1:0] aluOutM,
	input wire logic [`XLEN-1:0] writeDataM,
	input wire logic [4:0] writeRegM,
	output logic wbValid,
	output logic [4:0] wbReg,
	output logic [`XLEN-1:0] wbData
);

	localparam int DmemAw = $clog2(`DMEM_DEPTH);

	// Word address straight from the ALU result, wraps at depth
	logic [DmemAw-1:0] wordAddr;
	logic storeEn;
	logic [`XLEN-1:0] readData;
	logic memToRegW;
	logic [`XLEN-1:0] readDataW;
	logic [`XLEN-1:0] aluOutW;

	assign wordAddr = aluOutM[DmemAw-1:0];
	assign storeEn = validM && memWriteM;

	// --------------------
	// Byte lanes
	// --------------------

	// One array per byte, all lanes share the word address
	for (genvar b = 0; b < `XLEN / 8; b++)
	begin : gLane
		logic [7:0] lane [`DMEM_DEPTH];

		always_ff @(posedge clk)
		begin
			if (storeEn)
				lane[wordAddr] <= writeDataM[8*b +: 8];
		end

		// Combinational read
		assign readData[8*b +: 8] = lane[wordAddr];
	end

	// --------------------
	// MEM/WB register
	// --------------------

	// No write-back for stores, branches or register zero
	always_ff @(posedge clk)
	begin
		if (rst || !run)
			wbValid <= 1'b0;
		else
			wbValid <= validM && regWriteM && (writeRegM != 5'd0);
	end

	always_ff @(posedge clk)
	begin
		wbReg <= writeRegM;
		memToRegW <= memToRegM;
		readDataW <= readData;
		aluOutW <= aluOutM;
	end

	// Load data or ALU result
	assign wbData = memToRegW ? readDataW : aluOutW;

endmodule

`default_nettype wire

// File: logic/mipsPipe.sv
`default_nettype none

`include "mips_params.svh"

module mipsPipe
(
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic imemWe,
	input wire logic [`IMEM_AW-1:0] imemAddr,
	input wire logic [`XLEN-1:0] imemData,
	output logic wbValid,
	output logic [4:0] wbReg,
	output logic [`XLEN-1:0] wbData
);

	// --------------------
	// Stage wires
	// --------------------

	// IF/ID and branch feedback
	mipsPkg::instrT instrD;
	logic [`IMEM_AW-1:0] pcPlusOneD;
	logic validD;
	logic branchTaken;
	logic [`IMEM_AW-1:0] branchTarget;

	// ID/EX
	logic validE;
	logic regWriteE;
	logic memToRegE;
	logic memWriteE;
	logic aluSrcE;
	logic regDstE;
	mipsPkg::aluOpT aluOpE;
	logic [`XLEN-1:0] rd1E;
	logic [`XLEN-1:0] rd2E;
	logic [`XLEN-1:0] signImmE;
	logic [4:0] rtE;
	logic [4:0] rdE;

	// EX/MEM
	logic validM;
	logic regWriteM;
	logic memToRegM;
	logic memWriteM;
	logic [`XLEN-1:0] aluOutM;
	logic [`XLEN-1:0] writeDataM;
	logic [4:0] writeRegM;

	// --------------------
	// Stages
	// --------------------

	fetchStage uFetch
	(
		.clk(clk),
		.rst(rst),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.instrD(instrD),
		.pcPlusOneD(pcPlusOneD),
		.validD(validD)
	);

	// Write-back port loops back into the register file
	decodeStage uDecode
	(
		.clk(clk),
		.rst(rst),
		.run(run),
		.instrD(instrD),
		.pcPlusOneD(pcPlusOneD),
		.validD(validD),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.validE(validE),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.memWriteE(memWriteE),
		.aluSrcE(aluSrcE),
		.regDstE(regDstE),
		.aluOpE(aluOpE),
		.rd1E(rd1E),
		.rd2E(rd2E),
		.signImmE(signImmE),
		.rtE(rtE),
		.rdE(rdE)
	);

	aluExec uExec
	(
		.clk(clk),
		.rst(rst),
		.run(run),
		.validE(validE),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.memWriteE(memWriteE),
		.aluSrcE(aluSrcE),
		.regDstE(regDstE),
		.aluOpE(aluOpE),
		.rd1E(rd1E),
		.rd2E(rd2E),
		.signImmE(signImmE),
		.rtE(rtE),
		.rdE(rdE),
		.validM(validM),
		.regWriteM(regWriteM),
		.memToRegM(memToRegM),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.writeRegM(writeRegM)
	);

	dataMemory uMem
	(
		.clk(clk),
		.rst(rst),
		.run(run),
		.validM(validM),
		.regWriteM(regWriteM),
		.memToRegM(memToRegM),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.writeRegM(writeRegM),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

// File: tests/mipsRefModel.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// --------------------
// Random source
// --------------------

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsrState = 32'd4600;

// Destinations of the last two emitted instructions
logic [4:0] recent [2];

// ISA-level machine state, kept across programs like the DUT
logic [`XLEN-1:0] refRegs [`REG_COUNT];
logic [`XLEN-1:0] refMem [`DMEM_DEPTH];
logic refStored [`DMEM_DEPTH];

// One LFSR step per returned bit, first bit ends up on top
function automatic logic [31:0] randBits(int n);
	logic [31:0] v;
	logic b;
	v = '0;
	for (int k = 0; k < n; k++)
	begin
		b = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (b)
			lfsrState = lfsrState ^ 32'h80200003;
		v = {v[30:0], b};
	end
	return v;
endfunction

// --------------------
// Encoders
// --------------------

function automatic logic [31:0] encR(mipsPkg::functT fn, logic [4:0] rs, logic [4:0] rt,
	logic [4:0] rd);
	mipsPkg::instrT w;
	w.r.opcode = mipsPkg::opRtype;
	w.r.rs = rs;
	w.r.rt = rt;
	w.r.rd = rd;
	w.r.shamt = '0;
	w.r.funct = fn;
	return w;
endfunction

function automatic logic [31:0] encI(mipsPkg::opcodeT op, logic [4:0] rs, logic [4:0] rt,
	logic [15:0] imm);
	mipsPkg::instrT w;
	w.i.opcode = op;
	w.i.rs = rs;
	w.i.rt = rt;
	w.i.imm = imm;
	return w;
endfunction

// --------------------
// Program builder
// --------------------

// Register 0..7, never the target of the previous two instructions
function automatic logic [4:0] pickSrc();
	logic [4:0] r;
	for (int t = 0; t < 8; t++)
	begin
		r = 5'(randBits(3));
		if (r == 5'd0 || (r != recent[0] && r != recent[1]))
			return r;
	end
	// Register zero never conflicts
	return 5'd0;
endfunction

function automatic mipsPkg::functT pickFunct();
	case (randBits(3) % 5)
		0: return mipsPkg::fnAdd;
		1: return mipsPkg::fnSub;
		2: return mipsPkg::fnAnd;
		3: return mipsPkg::fnOr;
		default: return mipsPkg::fnSlt;
	endcase
endfunction

// Kind bits in mask: addi, R-type, sw, lw, beq; addi is the fallback
function automatic void buildProgram(int count, logic [4:0] mask);
	logic stored [`DMEM_DEPTH];
	logic branchSeen;
	logic [4:0] dst;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [DmemAw-1:0] adr;
	int kind;
	int off;
	stored = refStored;
	branchSeen = 1'b0;
	recent[0] = 5'd0;
	recent[1] = 5'd0;
	prog.delete();
	for (int i = 0; i < count; i++)
	begin
		kind = randBits(3) % 5;
		if (!mask[kind])
			kind = 0;
		adr = DmemAw'(randBits(DmemAw));
		// Loads only from words known to hold data
		if (kind == 3)
		begin
			for (int s = 0; s < `DMEM_DEPTH && !stored[adr]; s++)
				adr = adr + 1'b1;
			if (!stored[adr])
				kind = 0;
		end
		rs = pickSrc();
		rt = pickSrc();
		dst = 5'(randBits(3));
		case (kind)
			0: prog.push_back(encI(mipsPkg::opAddi, rs, dst, 16'(randBits(16))));
			1: prog.push_back(encR(pickFunct(), rs, rt, dst));
			2:
			begin
				prog.push_back(encI(mipsPkg::opSw, 5'd0, rt, 16'(adr)));
				// A store behind a forward branch might be skipped
				if (!branchSeen)
					stored[adr] = 1'b1;
				dst = 5'd0;
			end
			3: prog.push_back(encI(mipsPkg::opLw, 5'd0, dst, 16'(adr)));
			default:
			begin
				// Forward only, never past the halt word
				off = randBits(2);
				if (off > count - 1 - i)
					off = count - 1 - i;
				if (randBits(1) != 0)
					rt = rs;
				prog.push_back(encI(mipsPkg::opBeq, rs, rt, 16'(off)));
				branchSeen = 1'b1;
				dst = 5'd0;
			end
		endcase
		recent[1] = recent[0];
		recent[0] = dst;
	end
endfunction

// --------------------
// Reference ISA model
// --------------------

// Runs prog up to the trailing halt word and fills the expected write-backs
function automatic void runModel();
	mipsPkg::instrT w;
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] res;
	logic [`XLEN-1:0] ad;
	logic signed [`XLEN-1:0] simm;
	logic [DmemAw-1:0] mi;
	logic wr;
	logic [4:0] dst;
	int pc;
	int steps;
	pc = 0;
	steps = 0;
	res = '0;
	expReg.delete();
	expData.delete();
	while (pc < prog.size() - 1 && steps < 256)
	begin
		w = prog[pc];
		a = refRegs[w.r.rs];
		b = refRegs[w.r.rt];
		simm = {{16{w.i.imm[15]}}, w.i.imm};
		ad = a + simm;
		mi = ad[DmemAw-1:0];
		wr = 1'b0;
		dst = w.i.rt;
		pc++;
		steps++;
		case (w.r.opcode)
			mipsPkg::opRtype:
			begin
				wr = 1'b1;
				dst = w.r.rd;
				case (w.r.funct)
					mipsPkg::fnAdd: res = a + b;
					mipsPkg::fnSub: res = a - b;
					mipsPkg::fnAnd: res = a & b;
					mipsPkg::fnOr: res = a | b;
					mipsPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			mipsPkg::opAddi:
			begin
				wr = 1'b1;
				res = ad;
			end
			mipsPkg::opLw:
			begin
				wr = 1'b1;
				res = refMem[mi];
			end
			mipsPkg::opSw:
			begin
				refMem[mi] = b;
				refStored[mi] = 1'b1;
			end
			// Taken branch simply skips, the squashed slot never runs
			mipsPkg::opBeq:
			begin
				if (a == b)
					pc = pc + int'(simm);
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != 5'd0)
		begin
			refRegs[dst] = res;
			expReg.push_back(dst);
			expData.push_back(res);
		end
	end
endfunction

`endif

// File: tests/mipsPipeTb.sv
`default_nettype none

`include "mips_params.svh"

module mipsPipeTb;

	localparam int DmemAw = $clog2(`DMEM_DEPTH);

	logic clk;
	logic rst;
	logic run;
	logic imemWe;
	logic [`IMEM_AW-1:0] imemAddr;
	logic [`XLEN-1:0] imemData;
	logic wbValid;
	logic [4:0] wbReg;
	logic [`XLEN-1:0] wbData;

	// Current program and the write-backs still owed by the DUT
	logic [`XLEN-1:0] prog [$];
	logic [4:0] expReg [$];
	logic [`XLEN-1:0] expData [$];

	int errCount;
	int mismatchCount;

	`include "mipsRefModel.svh"

	mipsPipe uut
	(
		.clk(clk),
		.rst(rst),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// --------------------
	// Write-back checker
	// --------------------

	// Empty list means no write-back is allowed, loading included
	always @(posedge clk)
	begin
		if (wbValid)
		begin
			assert (expReg.size() > 0)
			else
			begin
				errCount++;
				$display("unexpected write-back to register %0d", wbReg);
			end
			if (expReg.size() > 0)
			begin
				assert (wbReg == expReg[0])
				else
				begin
					errCount++;
					mismatchCount++;
					$display("mismatch wbReg: got %h expected %h", wbReg, expReg[0]);
				end
				assert (wbData == expData[0])
				else
				begin
					errCount++;
					mismatchCount++;
					$display("mismatch wbData: got %h expected %h", wbData, expData[0]);
				end
				expReg.delete(0);
				expData.delete(0);
			end
		end
	end

	// --------------------
	// Load and run
	// --------------------

	// Halt word beq $0,$0,-1 spins without writing back
	task automatic loadAndRun();
		int waitCycles;
		prog.push_back(encI(mipsPkg::opBeq, 5'd0, 5'd0, 16'hffff));
		for (int k = 0; k < prog.size(); k++)
		begin
			@(negedge clk);
			imemWe = 1'b1;
			imemAddr = k[`IMEM_AW-1:0];
			imemData = prog[k];
		end
		@(negedge clk);
		imemWe = 1'b0;
		runModel();
		run = 1'b1;
		waitCycles = 0;
		while (expReg.size() > 0 && waitCycles < 200)
		begin
			@(negedge clk);
			waitCycles++;
		end
		assert (expReg.size() == 0)
		else
		begin
			errCount++;
			$display("write-backs stopped coming, %0d still expected", expReg.size());
			expReg.delete();
			expData.delete();
		end
		// Quiet window, any write-back here is extra
		repeat (12) @(negedge clk);
		run = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	// Register zero as target and as source
	task automatic buildZeroProgram();
		prog.delete();
		prog.push_back(encI(mipsPkg::opAddi, 5'd0, 5'd0, 16'h1234));
		prog.push_back(encI(mipsPkg::opAddi, 5'd0, 5'd2, 16'hfffb));
		prog.push_back(encR(mipsPkg::fnAdd, 5'd0, 5'd0, 5'd3));
		prog.push_back(encR(mipsPkg::fnSub, 5'd0, 5'd0, 5'd0));
		prog.push_back(encR(mipsPkg::fnOr, 5'd2, 5'd0, 5'd4));
		prog.push_back(encR(mipsPkg::fnSlt, 5'd2, 5'd0, 5'd5));
	endtask

	// --------------------
	// Sequence
	// --------------------

	initial
	begin
		errCount = 0;
		mismatchCount = 0;
		rst = 1'b1;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		refRegs = '{default: '0};
		refStored = '{default: 1'b0};
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// Idle with run low, checker flags any wbValid
		repeat (4) @(negedge clk);
		// R-type on addi values
		buildProgram(16, 5'b00011);
		loadAndRun();
		// Stores then loads
		buildProgram(20, 5'b01101);
		loadAndRun();
		// Taken and not-taken beq
		buildProgram(24, 5'b10011);
		loadAndRun();
		buildZeroProgram();
		loadAndRun();
		// Long mixed program
		buildProgram(40, 5'b11111);
		loadAndRun();
		$display("errors %0d: %0d mismatch, %0d other", errCount, mismatchCount,
			errCount - mismatchCount);
		if (errCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
+incdir+tests
common/mipsPkg.sv
fetch/fetchStage.sv
decode/decodeStage.sv
logic/aluExec.sv
logic/dataMemory.sv
logic/mipsPipe.sv
tests/mipsPipeTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= mipsPipeTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
